// File: cart_bus_pkg.sv
`include "gb_mapper_settings.svh"

package cart_bus_pkg;

	localparam int DL_ADDR_W = 25;   // byte address of the download stream

	// cpu cartridge request, 26 bits
	typedef struct packed {
		logic                         rd;
		logic                         wr;
		logic [`CART_ADDR_W-1:0]      addr;
		logic [7:0]                   wdata;
	} cart_req_t;

	// download write of one 16 bit word, 42 bits
	typedef struct packed {
		logic                         wr;
		logic [DL_ADDR_W-1:0]         addr;       // even byte address
		logic [15:0]                  data;       // odd byte in [15:8]
	} dl_write_t;

	// request to external rom storage, 24 bits
	typedef struct packed {
		logic                         rd;
		logic [`ROM_WADDR_W-1:0]      word_addr;
		logic                         hi_byte;    // selects the odd byte of the word
	} rom_req_t;

endpackage

// File: cart_header_capture.sv
`include "gb_mapper_settings.svh"

module cart_header_capture (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  cart_bus_pkg::dl_write_t      dl,
	output cart_types_pkg::cart_header_t header
);
	import cart_types_pkg::*;

	logic [7:0] type_byte;     // raw mapper type
	logic [7:0] rom_size;      // raw rom size code
	logic [7:0] ram_size;      // raw ram size code
	logic [7:0] cgb_flag;      // raw colour flag
	logic [9:0] rom_span;      // one past the largest bank number

	// -------------------------------------------------------------------------
	// grab the header bytes as the image streams past
	// -------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
			cgb_flag  <= 8'h00;
		end else if (dl.wr) begin
			if (dl.addr == `HDR_CGB_OFS)  cgb_flag  <= dl.data[15:8];
			if (dl.addr == `HDR_TYPE_OFS) type_byte <= dl.data[15:8];
			if (dl.addr == `HDR_SIZE_OFS) begin
				ram_size <= dl.data[15:8];
				rom_size <= dl.data[7:0];
			end
		end
	end

	assign rom_span = 10'd2 << rom_size[3:0];   // code n means 2^(n+1) banks

	always_comb begin
		case (type_byte)
			8'd1, 8'd2, 8'd3:                     header.kind = kind_mbc1;
			8'd5, 8'd6:                           header.kind = kind_mbc2;
			8'd15, 8'd16, 8'd17, 8'd18, 8'd19:    header.kind = kind_mbc3;
			8'd25, 8'd26, 8'd27, 8'd28, 8'd29,
			8'd30:                                header.kind = kind_mbc5;
			default:                              header.kind = kind_none;
		endcase
		if (rom_size <= 8'd8) header.rom_mask = rom_span[`ROM_BANK_W-1:0] - 1'b1;
		else                  header.rom_mask = 9'h07f;   // odd sizes fall back to 128 banks
		if (ram_size <= 8'd2)      header.ram_mask = 4'h0;   // 8 KiB or less, single bank
		else if (ram_size == 8'd3) header.ram_mask = 4'h3;   // 32 KiB
		else                       header.ram_mask = 4'hf;
		header.cgb_game = (cgb_flag == 8'h80) || (cgb_flag == 8'hc0);
	end

endmodule

// File: cart_ram.sv
`include "gb_mapper_settings.svh"

module cart_ram (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         cpu_ce,
	input  cart_bus_pkg::cart_req_t      cart,
	input  logic [`CRAM_ADDR_W-1:0]      cram_addr,
	input  cart_types_pkg::cart_header_t header,
	input  cart_types_pkg::bank_state_t  banks,
	output logic [7:0]                   cram_rdata,
	output logic                         cram_hit
);
	import cart_types_pkg::*;

	logic [7:0] mem [0:(1 << `CRAM_ADDR_W)-1];   // 16 banks of 8 KiB
	logic       in_cram;
	logic       ram_rd;
	logic       ram_wr;
	logic [7:0] ram_byte;      // stored byte at the current address
	logic [7:0] rd_shaped;     // byte the cpu gets to see

	assign in_cram  = (cart.addr[15:13] == `RGN_CRAM);
	assign ram_rd   = cpu_ce & cart.rd & in_cram;
	assign ram_wr   = cpu_ce & cart.wr & in_cram;   // writes ignore ram_enable
	assign ram_byte = mem[cram_addr];

	// read shaping by enable and mapper
	always_comb begin
		if (!banks.ram_enable)
			rd_shaped = 8'hff;                                  // disabled ram floats high
		else if (header.kind == kind_mbc2 && cart.addr[15:9] == `MBC2_RAM_PAGE)
			rd_shaped = {4'hf, ram_byte[3:0]};                  // only 4 bits exist
		else if (banks.rtc_mode)
			rd_shaped = 8'h00;                                  // no rtc model yet
		else
			rd_shaped = ram_byte;
	end

	// storage and read data
	always_ff @(posedge clk_sys) begin
		if (ram_wr) mem[cram_addr] <= cart.wdata;
		if (ram_rd) cram_rdata <= rd_shaped;
	end

	// hit flag marks the cycle after each read
	always_ff @(posedge clk_sys) begin
		if (reset) cram_hit <= 1'b0;
		else       cram_hit <= ram_rd;
	end

endmodule

// File: cart_types_pkg.sv
`include "gb_mapper_settings.svh"

package cart_types_pkg;

	// -------------------------------------------------------------------------
	// mapper kind as decoded from the header type byte
	// -------------------------------------------------------------------------
	typedef enum logic [2:0] {
		kind_none = 3'd0,   // plain 32 KiB rom, no banking
		kind_mbc1 = 3'd1,
		kind_mbc2 = 3'd2,
		kind_mbc3 = 3'd3,
		kind_mbc5 = 3'd4
	} mapper_kind_t;

	// decoded header record, 17 bits
	typedef struct packed {
		mapper_kind_t                 kind;
		logic [`ROM_BANK_W-1:0]       rom_mask;   // mirrors rom banks past the rom size
		logic [`RAM_BANK_W-1:0]       ram_mask;   // mirrors ram banks past the ram size
		logic                         cgb_game;   // colour flag 80h or c0h
	} cart_header_t;

	// -------------------------------------------------------------------------
	// cpu written bank controller state, 16 bits
	// -------------------------------------------------------------------------
	typedef struct packed {
		logic [`ROM_BANK_W-1:0]       rom_bank;
		logic [`RAM_BANK_W-1:0]       ram_bank;
		logic                         mbc1_mode;  // 1 selects ram banking on mbc1
		logic                         rtc_mode;   // mbc3 rtc mapped at a000
		logic                         ram_enable;
	} bank_state_t;

endpackage

// File: gb_cart_mapper.f
+incdir+.
cart_types_pkg.sv
cart_bus_pkg.sv
cart_header_capture.sv
mbc_registers.sv
mbc_address_map.sv
cart_ram.sv
gb_cart_mapper.sv
gb_cart_mapper_asserts.sv
gb_cart_mapper_tb.sv

// File: gb_cart_mapper.sv
`include "gb_mapper_settings.svh"

module gb_cart_mapper (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         cpu_ce,      // cpu clock enable
	input  cart_bus_pkg::cart_req_t      cart,
	input  cart_bus_pkg::dl_write_t      dl,
	output cart_bus_pkg::rom_req_t       rom,
	output logic [7:0]                   cram_rdata,
	output logic                         cram_hit,
	output logic                         cgb_game
);
	import cart_types_pkg::*;

	cart_header_t             header;      // decoded cartridge header
	bank_state_t              banks;       // current bank registers
	logic [`CRAM_ADDR_W-1:0]  cram_addr;

	// -------------------------------------------------------------------------
	// header, registers, address map, ram
	// -------------------------------------------------------------------------
	cart_header_capture u_header (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.header  (header)
	);

	mbc_registers u_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_ce  (cpu_ce),
		.cart    (cart),
		.header  (header),
		.banks   (banks)
	);

	mbc_address_map u_map (
		.cart      (cart),
		.header    (header),
		.banks     (banks),
		.rom       (rom),
		.cram_addr (cram_addr)
	);

	cart_ram u_cram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cart       (cart),
		.cram_addr  (cram_addr),
		.header     (header),
		.banks      (banks),
		.cram_rdata (cram_rdata),
		.cram_hit   (cram_hit)
	);

	assign cgb_game = header.cgb_game;   // tells the core to boot in colour mode

endmodule

// File: gb_cart_mapper_asserts.sv
`include "gb_mapper_settings.svh"

module gb_cart_mapper_asserts (
	input logic                         clk_sys,
	input logic                         reset,
	input logic                         cpu_ce,
	input cart_bus_pkg::cart_req_t      cart,
	input cart_types_pkg::cart_header_t header,
	input cart_types_pkg::bank_state_t  banks
);
	import cart_types_pkg::*;

	int   assert_fails = 0;   // failed assertion count
	logic reg_wr;             // cpu write in an enabled cycle

	assign reg_wr = cpu_ce & cart.wr;

	// reset loads bank 1
	reset_bank: assert property (@(posedge clk_sys) reset |=> banks.rom_bank == `ROM_BANK_W'd1)
		else begin
			assert_fails++;
			$error("rom_bank is not 1 after reset");
		end

	// -------------------------------------------------------------------------
	// register rules
	// -------------------------------------------------------------------------
	bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(reg_wr && cart.addr[15:13] == `RGN_ROM_BANK && header.kind != kind_mbc5)
		|=> banks.rom_bank[6:0] != 7'd0)
		else begin
			assert_fails++;
			$error("rom_bank low bits became 0 outside mbc5");
		end

	enable_on_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(reg_wr && cart.addr[15:13] == `RGN_RAM_EN) |=> $stable(banks.ram_enable))
		else begin
			assert_fails++;
			$error("ram_enable changed without a write to 0000-1fff");
		end

endmodule

bind mbc_registers gb_cart_mapper_asserts u_asserts (
	.clk_sys (clk_sys),
	.reset   (reset),
	.cpu_ce  (cpu_ce),
	.cart    (cart),
	.header  (header),
	.banks   (banks)
);

// File: gb_cart_mapper_tb.sv
`include "gb_mapper_settings.svh"

module gb_cart_mapper_tb;
	import cart_types_pkg::*;
	import cart_bus_pkg::*;

	typedef enum logic [2:0] {op_dl, op_wr, op_rw, op_rom, op_ram, op_cgb} op_t;

	localparam logic [23:0] E_MEM = 24'h000100;   // expect the shadow byte
	localparam logic [23:0] E_NIB = 24'h000200;   // expect fh above the shadow nibble
	localparam int HIT_TIMEOUT = 20;              // cycles to wait for cram_hit

	// one table row: action, address, data, expected value, shadow address
	typedef struct packed {
		op_t         op;
		logic [24:0] addr;
		logic [15:0] data;
		logic [23:0] exp;
		logic [16:0] sh;
	} step_t;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       cpu_ce;
	cart_req_t  cart;
	dl_write_t  dl;
	rom_req_t   rom;
	logic [7:0] cram_rdata;
	logic       cram_hit;
	logic       cgb_game;

	step_t       steps [$];
	logic [7:0]  shadow [0:(1 << `CRAM_ADDR_W)-1];   // model of the cartridge ram
	logic [15:0] lfsr = 16'd15756;
	int          value_errors = 0;
	int          timeout_errors = 0;
	int          assert_errors;

	gb_cart_mapper UUT (.*);

	always #10 clk_sys = ~clk_sys;   // 20 unit period

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);   // taps 16 14 13 11
	endfunction

	task automatic take_random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];          // one lfsr step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic add_step(input op_t op, input logic [24:0] addr, input logic [15:0] data,
			input logic [23:0] exp, input logic [16:0] sh);
		steps.push_back('{op, addr, data, exp, sh});
	endtask

	task automatic compare_rom(input rom_req_t got, input rom_req_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t rom got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [7:0] expected_ram(input step_t s);
		case (s.exp[9:8])
			2'd1:    return shadow[s.sh];
			2'd2:    return {4'hf, shadow[s.sh][3:0]};   // mbc2 keeps only the low nibble
			default: return s.exp[7:0];                  // fixed value ff or 00
		endcase
	endfunction

	// -------------------------------------------------------------------------
	// stimulus table
	// -------------------------------------------------------------------------
	task automatic build_table;
		add_step(op_rom, 25'h4a52, '0, {1'b1, 22'h002529, 1'b0}, '0);   // no header, bits 14:1
		add_step(op_dl, `HDR_TYPE_OFS, 16'h0100, '0, '0);   // mbc1
		add_step(op_dl, `HDR_SIZE_OFS, 16'h0303, '0, '0);   // 256 KiB rom, 32 KiB ram
		add_step(op_dl, `HDR_CGB_OFS, 16'hc000, '0, '0);
		add_step(op_cgb, '0, '0, 24'h1, '0);
		add_step(op_wr, 25'h2000, 16'h00, '0, '0);           // bank 0 turns into 1
		add_step(op_rom, 25'h4000, '0, {1'b1, 22'h002000, 1'b0}, '0);
		add_step(op_wr, 25'h2000, 16'h15, '0, '0);
		add_step(op_rom, 25'h5fff, '0, {1'b1, 22'h00afff, 1'b1}, '0);   // 15h masked to 5
		add_step(op_dl, `HDR_SIZE_OFS, 16'h0306, '0, '0);   // 2 MiB rom
		add_step(op_wr, 25'h4000, 16'h02, '0, '0);           // upper rom bits in mode 0
		add_step(op_rom, 25'h4002, '0, {1'b1, 22'h0aa001, 1'b0}, '0);
		add_step(op_wr, 25'h6000, 16'h01, '0, '0);           // mode 1 drops them
		add_step(op_rom, 25'h4002, '0, {1'b1, 22'h02a001, 1'b0}, '0);
		add_step(op_dl, `HDR_TYPE_OFS, 16'h1900, '0, '0);   // mbc5
		add_step(op_dl, `HDR_SIZE_OFS, 16'h0408, '0, '0);   // 8 MiB rom, 128 KiB ram
		add_step(op_wr, 25'h2000, 16'ha5, '0, '0);
		add_step(op_wr, 25'h3000, 16'h01, '0, '0);           // bank 1a5h
		add_step(op_rom, 25'h7ffe, '0, {1'b1, 22'h34bfff, 1'b0}, '0);
		add_step(op_rom, 25'h2001, '0, {1'b1, 22'h001000, 1'b1}, '0);   // fixed bank 0
		add_step(op_wr, 25'h0000, 16'h0a, '0, '0);           // ram on
		add_step(op_wr, 25'h4000, 16'h03, '0, '0);
		add_step(op_rw, 25'ha000, '0, '0, 17'h06000);
		add_step(op_rw, 25'hbfff, '0, '0, 17'h07fff);
		add_step(op_ram, 25'ha000, '0, E_MEM, 17'h06000);
		add_step(op_ram, 25'hbfff, '0, E_MEM, 17'h07fff);
		add_step(op_wr, 25'h0000, 16'h00, '0, '0);           // ram off
		add_step(op_ram, 25'ha000, '0, 24'hff, '0);
		add_step(op_dl, `HDR_TYPE_OFS, 16'h0500, '0, '0);   // mbc2
		add_step(op_wr, 25'h0000, 16'h0a, '0, '0);
		add_step(op_rw, 25'ha010, '0, '0, 17'h00010);
		add_step(op_ram, 25'ha010, '0, E_NIB, 17'h00010);
		add_step(op_dl, `HDR_TYPE_OFS, 16'h1300, '0, '0);   // mbc3
		add_step(op_dl, `HDR_SIZE_OFS, 16'h0306, '0, '0);   // ram mask 3
		add_step(op_wr, 25'h4000, 16'h01, '0, '0);
		add_step(op_rw, 25'ha055, '0, '0, 17'h02055);
		add_step(op_wr, 25'h4000, 16'h08, '0, '0);           // rtc select
		add_step(op_ram, 25'ha055, '0, 24'h00, '0);
		add_step(op_wr, 25'h4000, 16'h01, '0, '0);           // back to ram bank 1
		add_step(op_ram, 25'ha055, '0, E_MEM, 17'h02055);
		add_step(op_dl, `HDR_TYPE_OFS, 16'h1900, '0, '0);   // mbc5 again
		add_step(op_wr, 25'h4000, 16'h05, '0, '0);           // bank 5 aliases bank 1
		add_step(op_ram, 25'ha055, '0, E_MEM, 17'h02055);
	endtask

	// -------------------------------------------------------------------------
	// apply the table
	// -------------------------------------------------------------------------
	initial begin
		step_t      s;
		logic [7:0] b;
		bit         got_hit;
		reset  = 1'b1;
		cpu_ce = 1'b0;
		cart   = '0;
		dl     = '0;
		build_table();
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		foreach (steps[i]) begin
			s = steps[i];
			@(posedge clk_sys);
			case (s.op)
				op_dl: dl <= '{1'b1, s.addr, s.data};
				op_wr: begin
					cpu_ce <= 1'b1;
					cart   <= '{1'b0, 1'b1, s.addr[15:0], s.data[7:0]};
				end
				op_rw: begin
					take_random_byte(b);
					shadow[s.sh] = b;   // where the mapper should place it
					cpu_ce <= 1'b1;
					cart   <= '{1'b0, 1'b1, s.addr[15:0], b};
				end
				op_rom, op_ram: begin
					cpu_ce <= 1'b1;
					cart   <= '{1'b1, 1'b0, s.addr[15:0], 8'h00};
				end
				default: ;
			endcase
			@(negedge clk_sys);   // rom request is combinational, settled here
			if (s.op == op_rom) compare_rom(rom, s.exp);
			if (s.op == op_cgb) compare_byte("cgb_game", {7'd0, cgb_game}, s.exp[7:0]);
			if (s.op == op_wr || s.op == op_rw || s.op == op_ram) begin
				compare_byte("rom.rd", {7'd0, rom.rd}, 8'h00);   // no rom fetch here
			end
			compare_byte("cram_hit", {7'd0, cram_hit}, 8'h00);   // no read outstanding yet
			@(posedge clk_sys);
			cpu_ce  <= 1'b0;
			cart.rd <= 1'b0;
			cart.wr <= 1'b0;
			dl.wr   <= 1'b0;
			if (s.op == op_ram) begin
				got_hit = 1'b0;
				for (int t = 0; t < HIT_TIMEOUT && !got_hit; t++) begin
					@(negedge clk_sys);
					got_hit = cram_hit;
				end
				if (!got_hit) begin
					timeout_errors++;
					$display("no cram_hit within %0d cycles of the read at %h", HIT_TIMEOUT,
						s.addr[15:0]);
				end else begin
					compare_byte("cram_rdata", cram_rdata, expected_ram(s));
				end
			end
		end
		assert_errors = UUT.u_regs.u_asserts.assert_fails;
		$display("errors: %0d value, %0d timeout, %0d assertion", value_errors, timeout_errors,
			assert_errors);
		if (value_errors + timeout_errors + assert_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: gb_mapper_settings.svh
`ifndef GB_MAPPER_SETTINGS_SVH
`define GB_MAPPER_SETTINGS_SVH

// -------------------------------------------------------------------------
// bus and storage widths
// -------------------------------------------------------------------------
`define CART_ADDR_W    16              // cpu cartridge address
`define ROM_BANK_W     9               // up to 512 rom banks on mbc5
`define RAM_BANK_W     4               // up to 16 ram banks of 8 KiB
`define ROM_WADDR_W    22              // 9 bank bits above 13 word bits
`define CRAM_ADDR_W    17              // 128 KiB cartridge ram

// header byte offsets inside the downloaded image
`define HDR_CGB_OFS    25'h142         // colour flag in the odd byte
`define HDR_TYPE_OFS   25'h146         // mapper type in the odd byte
`define HDR_SIZE_OFS   25'h148         // rom size low byte, ram size high byte

// cpu regions selected by addr[15:13]
`define RGN_RAM_EN     3'b000          // 0000-1fff
`define RGN_ROM_BANK   3'b001          // 2000-3fff
`define RGN_RAM_BANK   3'b010          // 4000-5fff
`define RGN_MODE       3'b011          // 6000-7fff
`define RGN_CRAM       3'b101          // a000-bfff

`define MBC2_RAM_PAGE  7'b1010000      // addr[15:9] of the mbc2 nibble ram
`define RAM_ENABLE_KEY 4'ha            // low nibble that opens the ram

`endif

// File: mbc_address_map.sv
`include "gb_mapper_settings.svh"

module mbc_address_map (
	input  cart_bus_pkg::cart_req_t          cart,
	input  cart_types_pkg::cart_header_t     header,
	input  cart_types_pkg::bank_state_t      banks,
	output cart_bus_pkg::rom_req_t           rom,
	output logic [`CRAM_ADDR_W-1:0]          cram_addr
);
	import cart_types_pkg::*;

	logic [`ROM_BANK_W-1:0] rom_bank_eff;    // bank before masking
	logic [`ROM_BANK_W-1:0] rom_bank_msk;    // bank after size mirroring
	logic [`ROM_BANK_W-1:0] rom_bank_sel;    // bank 0 for the fixed window
	logic [`RAM_BANK_W-1:0] ram_bank_msk;
	logic [`RAM_BANK_W-1:0] ram_bank_sel;
	logic                   in_cram;         // access lands in a000-bfff

	// -------------------------------------------------------------------------
	// rom bank per mapper
	// -------------------------------------------------------------------------
	always_comb begin
		case (header.kind)
			kind_mbc1: begin
				// mode 0 routes the ram bank to the upper rom lines
				if (banks.mbc1_mode) rom_bank_eff = {4'b0000, banks.rom_bank[4:0]};
				else rom_bank_eff = {2'b00, banks.ram_bank[1:0], banks.rom_bank[4:0]};
			end
			kind_mbc2, kind_mbc3: rom_bank_eff = {2'b00, banks.rom_bank[6:0]};
			kind_mbc5:            rom_bank_eff = banks.rom_bank;
			default:              rom_bank_eff = '0;
		endcase
	end

	assign rom_bank_msk = rom_bank_eff & header.rom_mask;
	assign rom_bank_sel = cart.addr[14] ? rom_bank_msk : '0;   // 0000-3fff is always bank 0
	assign in_cram      = (cart.addr[15:13] == `RGN_CRAM);

	// word address into external rom, plain carts map 32 KiB linearly
	assign rom.rd      = cart.rd & ~in_cram;
	assign rom.hi_byte = cart.addr[0];
	assign rom.word_addr = (header.kind == kind_none) ?
		{{(`ROM_WADDR_W-14){1'b0}}, cart.addr[14:1]} :
		{rom_bank_sel, cart.addr[13:1]};

	// -------------------------------------------------------------------------
	// cartridge ram bank
	// -------------------------------------------------------------------------
	assign ram_bank_msk = banks.ram_bank & header.ram_mask;

	always_comb begin
		case (header.kind)
			kind_mbc1:            ram_bank_sel = banks.mbc1_mode ? ram_bank_msk : '0;
			kind_mbc3, kind_mbc5: ram_bank_sel = ram_bank_msk;
			default:              ram_bank_sel = '0;   // mbc2 and plain carts have one bank
		endcase
	end

	assign cram_addr = {ram_bank_sel, cart.addr[12:0]};

endmodule

// File: mbc_registers.sv
`include "gb_mapper_settings.svh"

module mbc_registers (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         cpu_ce,
	input  cart_bus_pkg::cart_req_t      cart,
	input  cart_types_pkg::cart_header_t header,
	output cart_types_pkg::bank_state_t  banks
);
	import cart_types_pkg::*;

	logic       reg_wr;     // cpu write in an enabled cycle
	logic [2:0] region;     // 8 KiB region of the access
	logic       is_mbc1;
	logic       is_mbc3;
	logic       is_mbc5;

	assign reg_wr  = cpu_ce & cart.wr;
	assign region  = cart.addr[15:13];
	assign is_mbc1 = (header.kind == kind_mbc1);
	assign is_mbc3 = (header.kind == kind_mbc3);
	assign is_mbc5 = (header.kind == kind_mbc5);

	// -------------------------------------------------------------------------
	// register writes into the rom area 0000-7fff
	// -------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			banks.rom_bank   <= `ROM_BANK_W'd1;   // bank 0 is never selected at 4000
			banks.ram_bank   <= '0;
			banks.mbc1_mode  <= 1'b0;
			banks.rtc_mode   <= 1'b0;
			banks.ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (region)
				`RGN_RAM_EN: begin
					banks.ram_enable <= (cart.wdata[3:0] == `RAM_ENABLE_KEY);
				end

				`RGN_ROM_BANK: begin
					if (is_mbc5) begin
						// mbc5 takes a full 8 bit bank, bank 0 allowed
						if (cart.addr[12])
							banks.rom_bank[8] <= cart.wdata[0];      // 3000-3fff high bit
						else
							banks.rom_bank[7:0] <= cart.wdata;       // 2000-2fff
					end else if (cart.wdata[6:0] == 7'd0) begin
						banks.rom_bank <= `ROM_BANK_W'd1;         // 0 maps to 1
					end else begin
						banks.rom_bank <= {2'b00, cart.wdata[6:0]};
					end
				end

				`RGN_RAM_BANK: begin
					if (is_mbc3) begin
						if (cart.wdata[3]) begin
							banks.rtc_mode <= 1'b1;   // rtc register at a000
						end else begin
							banks.rtc_mode <= 1'b0;
							banks.ram_bank <= {2'b00, cart.wdata[1:0]};
						end
					end else if (is_mbc5) begin
						banks.ram_bank <= cart.wdata[3:0];
					end else begin
						banks.ram_bank <= {2'b00, cart.wdata[1:0]};   // mbc1 upper bits too
					end
				end

				`RGN_MODE: begin
					if (is_mbc1) banks.mbc1_mode <= cart.wdata[0];   // only mbc1 has a mode
				end

				default: ;   // a000 and up is not a register
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cartridge mapper testbench with verilator
verilator --binary --timing --assert -Wno-fatal -f gb_cart_mapper.f --top-module gb_cart_mapper_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
out=$(./obj_dir/Vgb_cart_mapper_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
exit 1
